// File: imager_top.f
+incdir+hdl
hdl/imager_stream_pkg.sv
hdl/di_bus_pkg.sv
hdl/imager_terminal.sv
hdl/imager_source.sv
hdl/pixel_packer.sv
hdl/stream_capture.sv
hdl/imager_top.sv
sim/imager_top_tb.sv

// File: Bender.yml
package:
  name: imager_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/imager_stream_pkg.sv
      - hdl/di_bus_pkg.sv
      - hdl/imager_terminal.sv
      - hdl/imager_source.sv
      - hdl/pixel_packer.sv
      - hdl/stream_capture.sv
      - hdl/imager_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/imager_top_tb.sv

// File: sim/imager_trace.txt
# W term reg data | R term reg data status rdy | P count data... | C cycles
# values are hex, except the P count and the C cycles, which are decimal.
R 0020 0 00000000 0 0
R 0030 0 00000000 1 1
R 0010 0 00000000 0 1
W 0010 1 00000002
W 0010 2 00000004
W 0010 3 000003FC
W 0010 4 00000000
R 0010 1 00000002 0 1
R 0010 2 00000004 0 1
R 0010 3 000003FC 0 1
R 0010 5 00000000 0 1
# raw mode: frames 0 and 1 are captured, frame 2 runs with capture off.
W 0010 0 00000001
C 70
W 0010 0 00000000
C 40
R 0010 5 00000003 0 1
R 0020 1 00000014 0 1
P 5 F5000000 000003FC 000003FD 000003FE 000003FF
P 5 000003FD 000003FE 000003FF 00000000 FE000002
P 5 F5000001 000003FC 000003FD 000003FE 000003FF
P 5 000003FD 000003FE 000003FF 00000000 FE000002
R 0020 0 00000000 0 0
# packed mode: frames 3 and 4 are captured, frame 5 is dropped.
W 0010 4 00000001
R 0010 4 00000001 0 1
W 0010 0 00000001
C 71
W 0010 0 00000000
C 40
R 0010 5 00000006 0 1
R 0020 1 0000000C 0 1
P 6 F5000003 03FD03FC 03FF03FE 03FE03FD 000003FF FE000002
P 6 F5000004 03FD03FC 03FF03FE 03FE03FD 000003FF FE000002
# overflow: the FIFO keeps the oldest 64 words, from frame 6 on.
W 0010 4 00000000
W 0010 0 00000001
C 300
W 0010 0 00000000
C 40
R 0020 1 80000040 0 1
P 5 F5000006 000003FC 000003FD 000003FE 000003FF
P 6 000003FD 000003FE 000003FF 00000000 FE000002 F5000007
R 0020 1 80000035 0 1
W 0020 1 00000000
R 0020 1 00000035 0 1

// File: sim/imager_top_tb.sv
`default_nettype none
`include "imager_consts.svh"

module imager_top_tb
   import di_bus_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 4;
   localparam int POP_WAIT     = 20;
   localparam int MARGIN       = 200;

   logic          clk;
   logic          resetb;
   term_e         di_term_addr;
   di_addr_t      di_reg_addr;
   di_data_t      di_reg_datai;
   logic          di_write;
   logic          di_read;
   di_data_t      di_reg_datao;
   logic          di_read_rdy;
   xfer_status_e  di_transfer_status;

   // one entry per bus step, filled from the trace before the run starts.
   byte           cmd_q[$];
   logic [15:0]   term_q[$];
   logic [15:0]   addr_q[$];
   logic [31:0]   data_q[$];
   logic [15:0]   status_q[$];
   logic          rdy_q[$];

   int            checks;
   int            errors;
   int            limit_cycles;
   logic          limit_set;
   bit            trace_ok;

   imager_top dut (
      .clk                (clk),
      .resetb             (resetb),
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_reg_datai       (di_reg_datai),
      .di_write           (di_write),
      .di_read            (di_read),
      .di_reg_datao       (di_reg_datao),
      .di_read_rdy        (di_read_rdy),
      .di_transfer_status (di_transfer_status)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   function automatic void add_step(byte op, logic [15:0] term, logic [15:0] addr,
                                    logic [31:0] data, logic [15:0] status, logic rdy);
      cmd_q.push_back(op);
      term_q.push_back(term);
      addr_q.push_back(addr);
      data_q.push_back(data);
      status_q.push_back(status);
      rdy_q.push_back(rdy);
   endfunction

   task automatic load_trace(output bit ok);
      int                fd;
      int                code;
      int                count;
      logic [63:0]       cmd;
      logic [8*160-1:0]  line;
      logic [15:0]       term;
      logic [15:0]       addr;
      logic [31:0]       data;
      logic [15:0]       status;
      logic              rdy;
      ok = 1'b1;
      fd = $fopen("sim/imager_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file sim/imager_trace.txt");
         ok = 1'b0;
         return;
      end
      while ($fscanf(fd, "%s", cmd) == 1) begin
         if (cmd == "#") begin
            code = $fgets(line, fd);
         end else if (cmd == "W") begin
            code = $fscanf(fd, "%h %h %h", term, addr, data);
            if (code != 3) ok = 1'b0;
            add_step("W", term, addr, data, 16'd0, 1'b0);
         end else if (cmd == "R") begin
            code = $fscanf(fd, "%h %h %h %h %h", term, addr, data, status, rdy);
            if (code != 5) ok = 1'b0;
            add_step("R", term, addr, data, status, rdy);
         end else if (cmd == "P") begin
            code = $fscanf(fd, "%d", count);
            if (code != 1) ok = 1'b0;
            for (int k = 0; k < count; k++) begin
               code = $fscanf(fd, "%h", data);
               if (code != 1) ok = 1'b0;
               add_step("P", 16'(TERM_CAPTURE), `REG_CAPTURE_DATA, data, 16'd0, 1'b1);
            end
         end else if (cmd == "C") begin
            code = $fscanf(fd, "%d", data);
            if (code != 1) ok = 1'b0;
            add_step("C", 16'd0, 16'd0, data, 16'd0, 1'b0);
         end else begin
            $display("unknown command %s in the trace file", cmd);
            ok = 1'b0;
         end
      end
      $fclose(fd);
      if (!ok) begin
         $display("the trace file holds a malformed entry");
      end
   endtask

   // every bus task starts and ends 1 ns after a rising edge.
   task automatic reg_write(logic [15:0] term, logic [15:0] addr, logic [31:0] data);
      di_term_addr = term_e'(term);
      di_reg_addr  = addr;
      di_reg_datai = data;
      di_write     = 1'b1;
      @(posedge clk);
      #1;
      di_write = 1'b0;
   endtask

   task automatic read_expect(logic [15:0] term, logic [15:0] addr, logic [31:0] data,
                              logic [15:0] status, logic rdy);
      di_term_addr = term_e'(term);
      di_reg_addr  = addr;
      #1;
      checks++;
      assert (di_reg_datao == data && di_transfer_status == status && di_read_rdy == rdy)
         else begin
            errors++;
            $display("[ERROR] %0t ns: read %h/%h gave %h status %0d rdy %b, expected %h %0d %b",
                     $time, term, addr, di_reg_datao, di_transfer_status, di_read_rdy,
                     data, status, rdy);
         end
      @(posedge clk);
      #1;
   endtask

   task automatic pop_expect(logic [31:0] data);
      int   waited;
      logic ready;
      waited       = 0;
      di_term_addr = TERM_CAPTURE;
      di_reg_addr  = `REG_CAPTURE_DATA;
      #1;
      while (!di_read_rdy && waited < POP_WAIT) begin
         @(posedge clk);
         #2;
         waited++;
      end
      ready = di_read_rdy;
      checks++;
      assert (ready)
         else begin
            errors++;
            $display("the capture FIFO offered no word within %0d cycles", POP_WAIT);
         end
      if (ready) begin
         assert (di_reg_datao == data)
            else begin
               errors++;
               $display("[ERROR] %0t ns: popped %h, expected %h", $time, di_reg_datao, data);
            end
      end
      // the head word stays in place until the pop strobe of the next cycle.
      @(posedge clk);
      #1;
      if (ready) begin
         di_read = 1'b1;
         @(posedge clk);
         #1;
         di_read = 1'b0;
      end
   endtask

   task automatic run_trace();
      for (int i = 0; i < cmd_q.size(); i++) begin
         case (cmd_q[i])
            "W": reg_write(term_q[i], addr_q[i], data_q[i]);
            "R": read_expect(term_q[i], addr_q[i], data_q[i], status_q[i], rdy_q[i]);
            "P": pop_expect(data_q[i]);
            "C": begin
               repeat (data_q[i]) @(posedge clk);
               #1;
            end
            default: ;
         endcase
      end
   endtask

   initial begin
      resetb       = 1'b0;
      di_term_addr = TERM_IMAGER;
      di_reg_addr  = '0;
      di_reg_datai = '0;
      di_write     = 1'b0;
      di_read      = 1'b0;
      checks       = 0;
      errors       = 0;
      limit_set    = 1'b0;
      load_trace(trace_ok);
      if (!trace_ok) begin
         errors++;
      end
      // budget is every idle cycle plus the worst case of every other step.
      limit_cycles = RESET_CYCLES + MARGIN;
      foreach (cmd_q[i]) begin
         limit_cycles += (cmd_q[i] == "C") ? int'(data_q[i]) : POP_WAIT + 2;
      end
      limit_set = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      resetb = 1'b1;
      if (trace_ok) begin
         run_trace();
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      wait (limit_set);
      repeat (limit_cycles) @(posedge clk);
      $display("simulation timed out after %0d cycles before the trace finished", limit_cycles);
      $display("checks %0d, errors %0d", checks, errors);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/imager_top.sv
`default_nettype none
`include "imager_consts.svh"

module imager_top
   import di_bus_pkg::*, imager_stream_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      resetb,
   input  wire term_e     di_term_addr,
   input  wire di_addr_t  di_reg_addr,
   input  wire di_data_t  di_reg_datai,
   input  wire logic      di_write,
   input  wire logic      di_read,
   output di_data_t       di_reg_datao,
   output logic           di_read_rdy,
   output xfer_status_e   di_transfer_status
);

   logic                   enable;
   logic [`DIM_WIDTH-1:0]  num_rows;
   logic [`DIM_WIDTH-1:0]  num_cols;
   pixel_t                 pixel_base;
   stream_sel_e            stream_sel;
   logic [15:0]            frame_count;
   logic                   src_dv;
   dtype_e                 src_dtype;
   raw_word_t              src_data;
   logic                   pk_dv;
   dtype_e                 pk_dtype;
   packed_word_t           pk_data;
   logic                   sel_dv;
   packed_word_t           sel_data;
   di_data_t               imager_rdata;
   di_data_t               capture_rdata;
   logic                   capture_rdy;

   imager_terminal u_terminal (
      .clk          (clk),
      .resetb       (resetb),
      .di_term_addr (di_term_addr),
      .di_reg_addr  (di_reg_addr),
      .di_reg_datai (di_reg_datai),
      .di_write     (di_write),
      .frame_count  (frame_count),
      .reg_datao    (imager_rdata),
      .enable       (enable),
      .num_rows     (num_rows),
      .num_cols     (num_cols),
      .pixel_base   (pixel_base),
      .stream_sel   (stream_sel)
   );

   imager_source u_source (
      .clk         (clk),
      .resetb      (resetb),
      .enable      (enable),
      .num_rows    (num_rows),
      .num_cols    (num_cols),
      .pixel_base  (pixel_base),
      .dv          (src_dv),
      .dtype       (src_dtype),
      .data        (src_data),
      .frame_count (frame_count)
   );

   pixel_packer u_packer (
      .clk    (clk),
      .resetb (resetb),
      .dvi    (src_dv),
      .dtypei (src_dtype),
      .datai  (src_data),
      .dvo    (pk_dv),
      .dtypeo (pk_dtype),
      .datao  (pk_data)
   );

   // markers get their tag here so both paths deliver the same marker words.
   always_ff @(posedge clk) begin
      if (!resetb) begin
         sel_dv <= 1'b0;
      end else begin
         case (stream_sel)
            SEL_RAW:    sel_dv <= src_dv;
            SEL_PACKED: sel_dv <= pk_dv;
            default:    sel_dv <= 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (stream_sel)
         SEL_PACKED: sel_data <= tag_word(pk_dtype, pk_data);
         default:    sel_data <= tag_word(src_dtype, packed_word_t'(src_data));
      endcase
   end

   stream_capture u_capture (
      .clk          (clk),
      .resetb       (resetb),
      .enable       (enable),
      .dvi          (sel_dv),
      .datai        (sel_data),
      .di_term_addr (di_term_addr),
      .di_reg_addr  (di_reg_addr),
      .di_read      (di_read),
      .di_write     (di_write),
      .di_read_rdy  (capture_rdy),
      .reg_datao    (capture_rdata)
   );

   always_comb begin
      case (di_term_addr)
         TERM_IMAGER: begin
            di_reg_datao       = imager_rdata;
            di_read_rdy        = 1'b1;
            di_transfer_status = XFER_OK;
         end
         TERM_CAPTURE: begin
            di_reg_datao       = capture_rdata;
            di_read_rdy        = capture_rdy;
            di_transfer_status = XFER_OK;
         end
         default: begin
            di_reg_datao       = '0;
            di_read_rdy        = 1'b1;
            di_transfer_status = XFER_NO_TERMINAL;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/stream_capture.sv
`default_nettype none
`include "imager_consts.svh"

module stream_capture
   import di_bus_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      resetb,
   input  wire logic      enable,
   input  wire logic      dvi,
   input  wire di_data_t  datai,
   input  wire term_e     di_term_addr,
   input  wire di_addr_t  di_reg_addr,
   input  wire logic      di_read,
   input  wire logic      di_write,
   output logic           di_read_rdy,
   output di_data_t       reg_datao
);

   localparam int PTR_W = $clog2(`CAPTURE_DEPTH);
   localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(`CAPTURE_DEPTH);

   di_data_t          mem [`CAPTURE_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W:0]    level;
   logic              overflow;
   logic              empty;
   logic              full;
   logic              sel_data;
   logic              sel_status;
   logic              push;
   logic              pop;

   assign sel_data   = (di_term_addr == TERM_CAPTURE) && (di_reg_addr == `REG_CAPTURE_DATA);
   assign sel_status = (di_term_addr == TERM_CAPTURE) && (di_reg_addr == `REG_CAPTURE_STATUS);
   assign empty      = (level == '0);
   assign full       = (level == FULL_LEVEL);
   assign push       = enable && dvi && !full;
   assign pop        = di_read && sel_data && !empty;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= datai;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         level    <= '0;
         overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            level <= level + 1'b1;
         end else if (pop && !push) begin
            level <= level - 1'b1;
         end
         // a word dropped in the same cycle as the clear keeps the bit set.
         if (di_write && sel_status) begin
            overflow <= 1'b0;
         end
         if (enable && dvi && full) begin
            overflow <= 1'b1;
         end
      end
   end

   assign di_read_rdy = (di_reg_addr == `REG_CAPTURE_DATA) ? !empty : 1'b1;

   // the data register shows the oldest word without waiting for a pop.
   always_comb begin
      if (di_reg_addr == `REG_CAPTURE_DATA) begin
         reg_datao = empty ? '0 : mem[rd_ptr];
      end else if (di_reg_addr == `REG_CAPTURE_STATUS) begin
         reg_datao = {overflow, 15'd0, 16'(level)};
      end else begin
         reg_datao = '0;
      end
   end

   // the host pops only a word that di_read_rdy has offered.
   a_no_empty_pop: assert property (@(posedge clk) disable iff (!resetb)
      di_read && sel_data |-> !empty)
      else $error("capture FIFO popped while empty");

endmodule

`default_nettype wire

// File: hdl/pixel_packer.sv
`default_nettype none

module pixel_packer
   import imager_stream_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       resetb,
   input  wire logic       dvi,
   input  wire dtype_e     dtypei,
   input  wire raw_word_t  datai,
   output logic            dvo,
   output dtype_e          dtypeo,
   output packed_word_t    datao
);

   logic       have_even;
   raw_word_t  even_q;

   // a marker always restarts the pairing at an even column.
   always_ff @(posedge clk) begin
      if (!resetb) begin
         dvo       <= 1'b0;
         have_even <= 1'b0;
      end else begin
         dvo <= 1'b0;
         if (dvi) begin
            if (dtypei != DTYPE_PIXEL || have_even) begin
               dvo       <= 1'b1;
               have_even <= 1'b0;
            end else begin
               have_even <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dvi) begin
         if (dtypei == DTYPE_PIXEL) begin
            if (!have_even) begin
               even_q <= datai;
            end
            dtypeo <= DTYPE_PIXEL;
            datao  <= {datai, even_q};
         end else begin
            dtypeo <= dtypei;
            datao  <= packed_word_t'(datai);
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/imager_source.sv
`default_nettype none
`include "imager_consts.svh"

module imager_source
   import imager_stream_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   resetb,
   input  wire logic                   enable,
   input  wire logic [`DIM_WIDTH-1:0]  num_rows,
   input  wire logic [`DIM_WIDTH-1:0]  num_cols,
   input  wire pixel_t                 pixel_base,
   output logic                        dv,
   output dtype_e                      dtype,
   output raw_word_t                   data,
   output logic [15:0]                 frame_count
);

   localparam logic [`DIM_WIDTH-1:0] H_LAST = `DIM_WIDTH'(`H_BLANK - 1);
   localparam logic [`DIM_WIDTH-1:0] V_LAST = `DIM_WIDTH'(`V_BLANK - 1);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FRAME_START,
      S_LINE,
      S_HBLANK,
      S_VBLANK,
      S_FRAME_END
   } state_e;

   state_e                 state;
   logic [`DIM_WIDTH-1:0]  rows_q;
   logic [`DIM_WIDTH-1:0]  cols_q;
   logic [`DIM_WIDTH-1:0]  row;
   logic [`DIM_WIDTH-1:0]  col;
   logic [`DIM_WIDTH-1:0]  blank_cnt;
   pixel_t                 base_q;
   pixel_t                 pixel;
   logic                   start_frame;

   // enable is only looked at between frames.
   assign start_frame = enable && (state == S_IDLE || state == S_FRAME_END);
   assign pixel = pixel_t'(base_q + row + col);

   // the frame geometry is frozen for the whole frame.
   always_ff @(posedge clk) begin
      if (start_frame) begin
         rows_q <= num_rows;
         cols_q <= num_cols;
         base_q <= pixel_base;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state       <= S_IDLE;
         row         <= '0;
         col         <= '0;
         blank_cnt   <= '0;
         frame_count <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start_frame) begin
                  state <= S_FRAME_START;
               end
            end
            S_FRAME_START: begin
               row       <= '0;
               col       <= '0;
               blank_cnt <= '0;
               if (rows_q == '0 || cols_q == '0) begin
                  state <= S_VBLANK;
               end else begin
                  state <= S_LINE;
               end
            end
            S_LINE: begin
               if (col == cols_q - 1'b1) begin
                  col   <= '0;
                  state <= S_HBLANK;
               end else begin
                  col <= col + 1'b1;
               end
            end
            S_HBLANK: begin
               if (blank_cnt == H_LAST) begin
                  blank_cnt <= '0;
                  if (row == rows_q - 1'b1) begin
                     state <= S_VBLANK;
                  end else begin
                     row   <= row + 1'b1;
                     state <= S_LINE;
                  end
               end else begin
                  blank_cnt <= blank_cnt + 1'b1;
               end
            end
            S_VBLANK: begin
               if (blank_cnt == V_LAST) begin
                  blank_cnt <= '0;
                  state     <= S_FRAME_END;
               end else begin
                  blank_cnt <= blank_cnt + 1'b1;
               end
            end
            S_FRAME_END: begin
               frame_count <= frame_count + 1'b1;
               state       <= start_frame ? S_FRAME_START : S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         dv <= 1'b0;
      end else begin
         dv <= (state == S_FRAME_START) || (state == S_LINE) || (state == S_FRAME_END);
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         S_FRAME_START: begin
            dtype <= DTYPE_FRAME_START;
            data  <= frame_count;
         end
         S_FRAME_END: begin
            dtype <= DTYPE_FRAME_END;
            data  <= raw_word_t'(rows_q);
         end
         default: begin
            dtype <= DTYPE_PIXEL;
            data  <= raw_word_t'(pixel);
         end
      endcase
   end

   // past the first blanking cycle the last word of the line has left.
   a_no_word_in_blank: assert property (@(posedge clk) disable iff (!resetb)
      (state == S_HBLANK || state == S_VBLANK) && blank_cnt != '0 |-> !dv)
      else $error("stream word emitted during blanking");

endmodule

`default_nettype wire

// File: hdl/imager_terminal.sv
`default_nettype none
`include "imager_consts.svh"

module imager_terminal
   import di_bus_pkg::*, imager_stream_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              resetb,
   input  wire term_e             di_term_addr,
   input  wire di_addr_t          di_reg_addr,
   input  wire di_data_t          di_reg_datai,
   input  wire logic              di_write,
   input  wire logic [15:0]       frame_count,
   output di_data_t               reg_datao,
   output logic                   enable,
   output logic [`DIM_WIDTH-1:0]  num_rows,
   output logic [`DIM_WIDTH-1:0]  num_cols,
   output pixel_t                 pixel_base,
   output stream_sel_e            stream_sel
);

   logic wr_en;

   assign wr_en = di_write && (di_term_addr == TERM_IMAGER);

   always_ff @(posedge clk) begin
      if (!resetb) begin
         enable     <= 1'b0;
         num_rows   <= '0;
         num_cols   <= '0;
         pixel_base <= '0;
         stream_sel <= SEL_RAW;
      end else if (wr_en) begin
         case (di_reg_addr)
            `REG_ENABLE:     enable     <= di_reg_datai[0];
            `REG_NUM_ROWS:   num_rows   <= di_reg_datai[`DIM_WIDTH-1:0];
            `REG_NUM_COLS:   num_cols   <= di_reg_datai[`DIM_WIDTH-1:0];
            `REG_PIXEL_BASE: pixel_base <= di_reg_datai[`PIXEL_WIDTH-1:0];
            `REG_STREAM_SEL: stream_sel <= stream_sel_e'(di_reg_datai[1:0]);
            default: ;
         endcase
      end
   end

   // reads are combinational so the bus sees them in the same cycle.
   always_comb begin
      case (di_reg_addr)
         `REG_ENABLE:      reg_datao = di_data_t'(enable);
         `REG_NUM_ROWS:    reg_datao = di_data_t'(num_rows);
         `REG_NUM_COLS:    reg_datao = di_data_t'(num_cols);
         `REG_PIXEL_BASE:  reg_datao = di_data_t'(pixel_base);
         `REG_STREAM_SEL:  reg_datao = di_data_t'(stream_sel);
         `REG_FRAME_COUNT: reg_datao = di_data_t'(frame_count);
         default:          reg_datao = '0;
      endcase
   end

   // the packer pairs pixels within a line, so every line must hold an even count.
   a_even_cols: assert property (@(posedge clk) disable iff (!resetb)
      wr_en && (di_reg_addr == `REG_NUM_COLS) |-> !di_reg_datai[0])
      else $error("odd column count written to the imager terminal");

endmodule

`default_nettype wire

// File: hdl/di_bus_pkg.sv
`default_nettype none
`include "imager_consts.svh"

package di_bus_pkg;

   typedef logic [`DI_ADDR_WIDTH-1:0] di_addr_t;
   typedef logic [`DI_DATA_WIDTH-1:0] di_data_t;

   // terminal addresses on the register bus.
   typedef enum logic [15:0] {
      TERM_IMAGER  = 16'h0010,
      TERM_CAPTURE = 16'h0020
   } term_e;

   typedef enum logic [15:0] {
      XFER_OK          = 16'd0,
      XFER_NO_TERMINAL = 16'd1
   } xfer_status_e;

endpackage

`default_nettype wire

// File: hdl/imager_stream_pkg.sv
`default_nettype none
`include "imager_consts.svh"

package imager_stream_pkg;

   typedef logic [`PIXEL_WIDTH-1:0] pixel_t;
   typedef logic [15:0]             raw_word_t;
   typedef logic [31:0]             packed_word_t;

   typedef enum logic [1:0] {
      DTYPE_FRAME_START = 2'd0,
      DTYPE_PIXEL       = 2'd1,
      DTYPE_FRAME_END   = 2'd2
   } dtype_e;

   typedef enum logic [1:0] {
      SEL_RAW    = 2'd0,
      SEL_PACKED = 2'd1
   } stream_sel_e;

   // markers carry their payload in the low half and get their tag on top.
   function automatic packed_word_t tag_word(dtype_e dtype, packed_word_t data);
      packed_word_t word;
      case (dtype)
         DTYPE_FRAME_START: word = {`FRAME_START_TAG, data[15:0]};
         DTYPE_FRAME_END:   word = {`FRAME_END_TAG, data[15:0]};
         default:           word = data;
      endcase
      return word;
   endfunction

endpackage

`default_nettype wire

// File: hdl/imager_consts.svh
`ifndef IMAGER_CONSTS_SVH
`define IMAGER_CONSTS_SVH

// stream and register bus widths.
`define PIXEL_WIDTH    10
`define DIM_WIDTH      12
`define DI_DATA_WIDTH  32
`define DI_ADDR_WIDTH  16

`define CAPTURE_DEPTH  64

// idle cycles after every line and after the last line of a frame.
`define H_BLANK        4
`define V_BLANK        16

// upper halves of the frame marker words.
`define FRAME_START_TAG 16'hF500
`define FRAME_END_TAG   16'hFE00

// imager terminal registers.
`define REG_ENABLE      16'd0
`define REG_NUM_ROWS    16'd1
`define REG_NUM_COLS    16'd2
`define REG_PIXEL_BASE  16'd3
`define REG_STREAM_SEL  16'd4
`define REG_FRAME_COUNT 16'd5

// capture terminal registers.
`define REG_CAPTURE_DATA   16'd0
`define REG_CAPTURE_STATUS 16'd1

`endif
